// File: Bender.yml
package:
  name: qsim

sources:
  - target: any(synthesis, simulation)
    include_dirs:
      - rtl
    files:
      - rtl/qsim_pkg.sv
      - rtl/qsim_ctrl.sv
      - rtl/qsim_addr_gen.sv
      - rtl/qsim_cmac.sv
      - rtl/qsim_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - bench/qsim_tb.sv

// File: bench/qsim_tb.sv
`timescale 1ns/10ps
`include "qsim_defs.svh"

module qsim_tb import qsim_pkg::*; ();

  localparam int CLK_PERIOD = 10;

  logic  clk;
  logic  reset_n;
  logic  dut_valid;
  logic  dut_ready;
  logic  in_we, scr_we, out_we;
  addr_t in_wa, scr_wa, out_wa;
  addr_t in_ra, scr_ra, out_ra, gate_ra;
  cplx_t in_wd, scr_wd, out_wd;
  cplx_t in_rd, scr_rd, out_rd, gate_rd;

  // sram contents
  cplx_t in_mem [0:31];
  cplx_t scr_mem [0:31];
  cplx_t out_mem [0:31];
  cplx_t gate_mem [0:1023];

  // reference results
  cplx_t exp_final [0:15];
  cplx_t exp_prev [0:15];

  logic [31:0] lfsr;
  string cur_name;
  int    cur_q;
  int    cur_m;
  event  run_finished;
  event  compare_done;

  qsim_top qsim_top_i (
    .clk                               (clk),
    .reset_n                           (reset_n),
    .dut_valid                         (dut_valid),
    .dut_ready                         (dut_ready),
    .q_state_input_sram_write_enable   (in_we),
    .q_state_input_sram_write_address  (in_wa),
    .q_state_input_sram_write_data     (in_wd),
    .q_state_input_sram_read_address   (in_ra),
    .q_state_input_sram_read_data      (in_rd),
    .q_state_output_sram_write_enable  (out_we),
    .q_state_output_sram_write_address (out_wa),
    .q_state_output_sram_write_data    (out_wd),
    .q_state_output_sram_read_address  (out_ra),
    .q_state_output_sram_read_data     (out_rd),
    .scratchpad_sram_write_enable      (scr_we),
    .scratchpad_sram_write_address     (scr_wa),
    .scratchpad_sram_write_data        (scr_wd),
    .scratchpad_sram_read_address      (scr_ra),
    .scratchpad_sram_read_data         (scr_rd),
    .q_gates_sram_read_address         (gate_ra),
    .q_gates_sram_read_data            (gate_rd)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ----------------------------------------
  // sram models, one cycle read latency
  // ----------------------------------------

  always @(posedge clk) begin
    if (in_we) in_mem[in_wa] <= in_wd;
    if (scr_we) scr_mem[scr_wa] <= scr_wd;
    if (out_we) out_mem[out_wa] <= out_wd;
    in_rd   <= in_mem[in_ra];
    scr_rd  <= scr_mem[scr_ra];
    out_rd  <= out_mem[out_ra];
    gate_rd <= gate_mem[gate_ra];
  end

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------

  // galois lfsr, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return bits;
  endfunction

  // -1.0 up to just under +1.0
  function automatic part_t rand_part();
    return part_t'(int'(rand_bits(15)) - 16384);
  endfunction

  // unwritten words stay recognizable
  function automatic cplx_t fill_word(input logic [15:0] salt, input int addr);
    return {16'(addr) ^ salt, ~16'(addr)};
  endfunction

  task automatic load_test(input int q, input int m, input bit identity);
    int n, i, k;
    n = 1 << q;
    for (i = 0; i < 32; i++) begin
      in_mem[i]  = fill_word(16'h1111, i);
      scr_mem[i] = fill_word(16'h2222, i);
      out_mem[i] = fill_word(16'h3333, i);
    end
    // header, Q upper half and M lower half
    in_mem[0] = {16'(q), 16'(m)};
    for (i = 1; i <= n; i++) begin
      in_mem[i].re = rand_part();
      in_mem[i].im = rand_part();
    end
    // row-major, gate after gate
    for (k = 0; k < m * n * n; k++) begin
      if (identity) begin
        gate_mem[k] = ((k % (n * n)) / n == k % n) ? {16'sd16384, 16'sd0} : '0;
      end else begin
        gate_mem[k].re = rand_part();
        gate_mem[k].im = rand_part();
      end
    end
  endtask

  // ----------------------------------------
  // reference model
  // ----------------------------------------

  // 32-bit products, shift out fraction, keep 16 bits
  function automatic cplx_t mul_term(input cplx_t b, input cplx_t a);
    int p_re;
    int p_im;
    cplx_t t;
    p_re = int'(b.re) * int'(a.re) - int'(b.im) * int'(a.im);
    p_im = int'(b.re) * int'(a.im) + int'(b.im) * int'(a.re);
    t.re = part_t'(p_re >>> `QSIM_FRAC_BITS);
    t.im = part_t'(p_im >>> `QSIM_FRAC_BITS);
    return t;
  endfunction

  // final state plus the state the last gate started from
  function automatic void run_reference(input int q, input int m);
    cplx_t cur [0:15];
    cplx_t nxt [0:15];
    cplx_t acc;
    cplx_t t;
    int n, k, r, c;
    n = 1 << q;
    for (r = 0; r < n; r++) cur[r] = in_mem[r + 1];
    for (k = 0; k < m; k++) begin
      for (r = 0; r < n; r++) begin
        acc = '0;
        for (c = 0; c < n; c++) begin
          t = mul_term(gate_mem[k * n * n + r * n + c], cur[c]);
          // 16-bit wraparound sum
          acc.re = acc.re + t.re;
          acc.im = acc.im + t.im;
        end
        nxt[r] = acc;
      end
      exp_prev = cur;
      cur = nxt;
    end
    exp_final = cur;
  endfunction

  // ----------------------------------------
  // checks
  // ----------------------------------------

  task automatic check_amp(input string name, input cplx_t expected, input cplx_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %h actual %h", name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %b actual %b", name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %h actual %h", name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic compare_state();
    int n, r;
    bit final_in_input;
    n = 1 << cur_q;
    // even M means the last gate read scratch and wrote input
    final_in_input = (cur_m % 2 == 0);
    check_amp({cur_name, " header"}, {16'(cur_q), 16'(cur_m)}, in_mem[0]);
    for (r = 0; r < n; r++) begin
      check_amp($sformatf("%s output[%0d]", cur_name, r), exp_final[r], out_mem[r]);
      check_amp($sformatf("%s input[%0d]", cur_name, r + 1),
                final_in_input ? exp_final[r] : exp_prev[r], in_mem[r + 1]);
      check_amp($sformatf("%s scratch[%0d]", cur_name, r),
                final_in_input ? exp_prev[r] : exp_final[r], scr_mem[r]);
    end
  endtask

  // compare after each run
  initial begin
    forever begin
      @(run_finished);
      compare_state();
      -> compare_done;
    end
  end

  task automatic start_run(input string name, input int q, input int m, input bit hold_valid);
    cur_name = name;
    cur_q = q;
    cur_m = m;
    run_reference(q, m);
    @(posedge clk);
    #1 dut_valid = 1'b1;
    @(posedge clk);
    #1 dut_valid = hold_valid;
    check_bit({name, " busy"}, 1'b0, dut_ready);
    // dut_ready rising marks the last write
    while (!dut_ready) begin
      @(posedge clk);
      #1;
    end
    dut_valid = 1'b0;
    -> run_finished;
    @(compare_done);
    // no restart from a held dut_valid
    @(posedge clk);
    #1 check_bit({name, " idle after run"}, 1'b1, dut_ready);
  endtask

  // ----------------------------------------
  // watchdog
  // ----------------------------------------

  function automatic int run_cycles(input int q, input int m);
    return m * ((1 << (2 * q)) + 16);
  endfunction

  initial begin : watchdog
    int budget;
    budget = 4 * (run_cycles(1, 1) + run_cycles(2, 3) + run_cycles(4, 2)
                  + run_cycles(2, 2) + run_cycles(3, 1));
    #(budget * CLK_PERIOD);
    $display("watchdog expired, dut_ready did not return within %0d cycles", budget);
    $display("** FAIL **");
    $fatal(1, "simulation hung");
  end

  // ----------------------------------------
  // test sequence
  // ----------------------------------------

  initial begin : main
    int i;
    lfsr = 32'h1223_3598;
    reset_n = 1'b0;
    dut_valid = 1'b0;
    repeat (2) @(posedge clk);
    #1 reset_n = 1'b1;
    // idle after reset, nothing written, read ports parked at 0
    for (i = 0; i < 4; i++) begin
      check_bit("reset_idle dut_ready", 1'b1, dut_ready);
      check_bit("reset_idle input we", 1'b0, in_we);
      check_bit("reset_idle scratch we", 1'b0, scr_we);
      check_bit("reset_idle output we", 1'b0, out_we);
      check_addr("reset_idle input ra", '0, in_ra);
      check_addr("reset_idle scratch ra", '0, scr_ra);
      check_addr("reset_idle output ra", '0, out_ra);
      check_addr("reset_idle gate ra", '0, gate_ra);
      @(posedge clk);
      #1;
    end
    load_test(1, 1, 1'b1);
    start_run("identity_q1_m1", 1, 1, 1'b0);
    load_test(2, 3, 1'b0);
    start_run("random_q2_m3", 2, 3, 1'b0);
    load_test(4, 2, 1'b0);
    start_run("random_q4_m2", 4, 2, 1'b0);
    // dut_valid held high through the busy phase
    load_test(2, 2, 1'b0);
    start_run("busy_valid_q2_m2", 2, 2, 1'b1);
    load_test(3, 1, 1'b0);
    start_run("second_run_q3_m1", 3, 1, 1'b0);
    $display("** PASS **");
    $finish;
  end

endmodule

// File: flist.f
+incdir+rtl
rtl/qsim_pkg.sv
rtl/qsim_ctrl.sv
rtl/qsim_addr_gen.sv
rtl/qsim_cmac.sv
rtl/qsim_top.sv
bench/qsim_tb.sv

// File: rtl/qsim_addr_gen.sv
`timescale 1ns/10ps
`include "qsim_defs.svh"

module qsim_addr_gen import qsim_pkg::*; (
  input  logic    clk,
  input  logic    reset_n,
  input  logic    gen_start,
  input  qubits_t num_qubits,
  input  addr_t   gate_base,
  input  logic    src_is_scratch,
  input  logic    result_valid,
  output addr_t   state_read_address,
  output addr_t   gate_read_address,
  output logic    term_valid,
  output logic    term_first,
  output logic    term_last,
  output logic    input_write_enable,
  output addr_t   input_write_address,
  output logic    scratch_write_enable,
  output addr_t   scratch_write_address,
  output logic    output_write_enable,
  output addr_t   output_write_address,
  output logic    gen_done
);

  logic [2*`QSIM_MAX_QUBITS-1:0] sweep_cnt;
  logic  rd_busy;
  addr_t col_mask;
  addr_t last_idx;
  addr_t column;
  logic  sweep_end;
  addr_t row_cnt;
  addr_t wr_row;
  logic  wr_strobe;

  // 2^Q - 1 is both the column mask and the last row
  assign col_mask  = (addr_t'(1) << num_qubits) - addr_t'(1);
  assign last_idx  = (addr_t'(1) << {num_qubits, 1'b0}) - addr_t'(1);
  assign column    = addr_t'(sweep_cnt) & col_mask;
  assign sweep_end = (addr_t'(sweep_cnt) == last_idx);

  // ----------------------------------------
  // read sweep
  // ----------------------------------------

  // 4^Q indices, row-major, one per cycle
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rd_busy   <= 1'b0;
      sweep_cnt <= '0;
    end else if (gen_start) begin
      rd_busy   <= 1'b1;
      sweep_cnt <= '0;
    end else if (rd_busy) begin
      rd_busy   <= !sweep_end;
      sweep_cnt <= sweep_cnt + 1'b1;
    end
  end

  // input sram state starts at word 1, behind the header
  assign state_read_address = rd_busy ? column + addr_t'(!src_is_scratch) : '0;
  assign gate_read_address  = rd_busy ? gate_base + addr_t'(sweep_cnt) : '0;

  // tags line up with read data, one cycle behind
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      term_valid <= 1'b0;
      term_first <= 1'b0;
      term_last  <= 1'b0;
    end else begin
      term_valid <= rd_busy;
      term_first <= rd_busy && (column == '0);
      term_last  <= rd_busy && (column == col_mask);
    end
  end

  // ----------------------------------------
  // write-back
  // ----------------------------------------

  // one row sum per result_valid, in row order
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_strobe <= 1'b0;
      gen_done  <= 1'b0;
      row_cnt   <= '0;
      wr_row    <= '0;
    end else begin
      wr_strobe <= result_valid;
      gen_done  <= wr_strobe && (wr_row == col_mask);
      if (gen_start) begin
        row_cnt <= '0;
      end else if (result_valid) begin
        row_cnt <= row_cnt + 1'b1;
        wr_row  <= row_cnt;
      end
    end
  end

  // ping-pong target, output sram always written
  assign input_write_enable    = wr_strobe && src_is_scratch;
  assign scratch_write_enable  = wr_strobe && !src_is_scratch;
  assign output_write_enable   = wr_strobe;
  assign input_write_address   = wr_strobe ? wr_row + addr_t'(1) : '0;
  assign scratch_write_address = wr_strobe ? wr_row : '0;
  assign output_write_address  = wr_strobe ? wr_row : '0;

endmodule

// File: rtl/qsim_cmac.sv
`timescale 1ns/10ps
`include "qsim_defs.svh"

module qsim_cmac import qsim_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  src_is_scratch,
  input  cplx_t input_amp,
  input  cplx_t scratch_amp,
  input  cplx_t coef,
  input  logic  term_valid,
  input  logic  term_first,
  input  logic  term_last,
  output cplx_t result,
  output logic  result_valid
);

  cplx_t amp;
  logic signed [2*`QSIM_PART_W-1:0] p_rr_q;
  logic signed [2*`QSIM_PART_W-1:0] p_ii_q;
  logic signed [2*`QSIM_PART_W-1:0] p_ri_q;
  logic signed [2*`QSIM_PART_W-1:0] p_ir_q;
  logic signed [2*`QSIM_PART_W-1:0] diff_re;
  logic signed [2*`QSIM_PART_W-1:0] sum_im;
  logic  s1_valid, s1_first, s1_last;
  part_t term_re_q, term_im_q;
  logic  s2_valid, s2_first, s2_last;
  part_t acc_re, acc_im;
  part_t next_re, next_im;

  // current state lives on the ping-pong read side
  assign amp = src_is_scratch ? scratch_amp : input_amp;

  // ----------------------------------------
  // stage 1 partial products
  // ----------------------------------------

  always_ff @(posedge clk) begin
    p_rr_q <= coef.re * amp.re;
    p_ii_q <= coef.im * amp.im;
    p_ri_q <= coef.re * amp.im;
    p_ir_q <= coef.im * amp.re;
  end

  // ----------------------------------------
  // stage 2 combine and rescale
  // ----------------------------------------

  assign diff_re = p_rr_q - p_ii_q;
  assign sum_im  = p_ri_q + p_ir_q;

  // drop fraction bits, truncate to one part
  always_ff @(posedge clk) begin
    term_re_q <= part_t'(diff_re >>> `QSIM_FRAC_BITS);
    term_im_q <= part_t'(sum_im >>> `QSIM_FRAC_BITS);
  end

  // ----------------------------------------
  // stage 3 row accumulate
  // ----------------------------------------

  // first term restarts the row, 16-bit wraparound
  assign next_re = (s2_first ? part_t'(0) : acc_re) + term_re_q;
  assign next_im = (s2_first ? part_t'(0) : acc_im) + term_im_q;

  always_ff @(posedge clk) begin
    if (s2_valid) begin
      acc_re <= next_re;
      acc_im <= next_im;
    end
    // held until the next row closes
    if (s2_valid && s2_last) begin
      result.re <= next_re;
      result.im <= next_im;
    end
  end

  // tag pipeline follows the data
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      {s1_valid, s1_first, s1_last} <= 3'b000;
      {s2_valid, s2_first, s2_last} <= 3'b000;
      result_valid <= 1'b0;
    end else begin
      {s1_valid, s1_first, s1_last} <= {term_valid, term_first, term_last};
      {s2_valid, s2_first, s2_last} <= {s1_valid, s1_first, s1_last};
      result_valid <= s2_valid && s2_last;
    end
  end

endmodule

// File: rtl/qsim_ctrl.sv
`timescale 1ns/10ps

module qsim_ctrl import qsim_pkg::*; (
  input  logic    clk,
  input  logic    reset_n,
  input  logic    dut_valid,
  input  cplx_t   header,
  input  logic    gen_done,
  output logic    dut_ready,
  output logic    gen_start,
  output qubits_t num_qubits,
  output addr_t   gate_base,
  output logic    src_is_scratch
);

  ctrl_state_t state;
  ctrl_state_t state_next;
  gate_cnt_t   gates_left;
  addr_t       gate_size;
  logic        last_gate;

  // 4^Q coefficients per gate matrix
  assign gate_size = addr_t'(1) << {num_qubits, 1'b0};
  // counting down, one means final gate
  assign last_gate = (gates_left == gate_cnt_t'(1));

  // ----------------------------------------
  // state machine
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      // header address 0 is on the read port here
      IDLE: if (dut_valid) state_next = FETCH_HEADER;
      // header word arrives this cycle
      FETCH_HEADER: state_next = SETUP;
      SETUP: state_next = RUN_GATE;
      RUN_GATE: begin
        if (gen_done) begin
          state_next = last_gate ? IDLE : NEXT_GATE;
        end
      end
      NEXT_GATE: state_next = RUN_GATE;
      default: state_next = IDLE;
    endcase
  end

  // busy from the edge after dut_valid until the final gen_done
  assign dut_ready = (state == IDLE);
  // one pulse per gate, both states last a single cycle
  assign gen_start = (state == SETUP) || (state == NEXT_GATE);

  // ----------------------------------------
  // run registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      num_qubits     <= '0;
      gates_left     <= '0;
      gate_base      <= '0;
      src_is_scratch <= 1'b0;
    end else begin
      case (state)
        FETCH_HEADER: begin
          // Q upper half, M lower half
          num_qubits     <= qubits_t'(header.re);
          gates_left     <= gate_cnt_t'(header.im);
          gate_base      <= '0;
          src_is_scratch <= 1'b0;
        end
        RUN_GATE: begin
          // gate boundary, step base and swap ping-pong side
          if (gen_done && !last_gate) begin
            gates_left     <= gates_left - 1'b1;
            gate_base      <= gate_base + gate_size;
            src_is_scratch <= ~src_is_scratch;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

// File: rtl/qsim_defs.svh
`ifndef QSIM_DEFS_SVH
`define QSIM_DEFS_SVH

// ----------------------------------------
// sram geometry
// ----------------------------------------

// address width shared by all four srams
`define QSIM_ADDR_W 16

// ----------------------------------------
// fixed-point amplitude format
// ----------------------------------------

// one real or imaginary part, signed
`define QSIM_PART_W 16
// fraction bits, so 1.0 is 16384
`define QSIM_FRAC_BITS 14

// qubit count limits
`define QSIM_MAX_QUBITS 4
`define QSIM_QUBIT_W 3

`endif

// File: rtl/qsim_pkg.sv
`include "qsim_defs.svh"

package qsim_pkg;

  // ----------------------------------------
  // data words
  // ----------------------------------------

  // one signed fixed-point part
  typedef logic signed [`QSIM_PART_W-1:0] part_t;

  // complex amplitude, re in upper half
  // also one sram data word
  typedef struct packed {
    part_t re;
    part_t im;
  } cplx_t;

  // ----------------------------------------
  // control fields
  // ----------------------------------------

  typedef logic [`QSIM_ADDR_W-1:0] addr_t;
  typedef logic [`QSIM_QUBIT_W-1:0] qubits_t;
  typedef logic [15:0] gate_cnt_t;

  // run controller states
  typedef enum logic [2:0] {
    IDLE,
    FETCH_HEADER,
    SETUP,
    RUN_GATE,
    NEXT_GATE
  } ctrl_state_t;

endpackage

// File: rtl/qsim_top.sv
`timescale 1ns/10ps

module qsim_top import qsim_pkg::*; (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  dut_valid,
  output logic  dut_ready,
  // input state sram
  output logic  q_state_input_sram_write_enable,
  output addr_t q_state_input_sram_write_address,
  output cplx_t q_state_input_sram_write_data,
  output addr_t q_state_input_sram_read_address,
  input  cplx_t q_state_input_sram_read_data,
  // output state sram
  output logic  q_state_output_sram_write_enable,
  output addr_t q_state_output_sram_write_address,
  output cplx_t q_state_output_sram_write_data,
  output addr_t q_state_output_sram_read_address,
  input  cplx_t q_state_output_sram_read_data,
  // scratchpad sram
  output logic  scratchpad_sram_write_enable,
  output addr_t scratchpad_sram_write_address,
  output cplx_t scratchpad_sram_write_data,
  output addr_t scratchpad_sram_read_address,
  input  cplx_t scratchpad_sram_read_data,
  // gate sram, read only
  output addr_t q_gates_sram_read_address,
  input  cplx_t q_gates_sram_read_data
);

  logic    gen_start;
  logic    gen_done;
  logic    src_is_scratch;
  qubits_t num_qubits;
  addr_t   gate_base;
  addr_t   state_read_address;
  logic    term_valid, term_first, term_last;
  cplx_t   result;
  logic    result_valid;

  // both state srams read in lockstep, cmac picks one
  assign q_state_input_sram_read_address  = state_read_address;
  assign scratchpad_sram_read_address     = state_read_address;
  // output sram is write only here
  assign q_state_output_sram_read_address = '0;

  // one row sum feeds every write port
  assign q_state_input_sram_write_data  = result;
  assign q_state_output_sram_write_data = result;
  assign scratchpad_sram_write_data     = result;

  qsim_ctrl qsim_ctrl_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .dut_valid      (dut_valid),
    .header         (q_state_input_sram_read_data),
    .gen_done       (gen_done),
    .dut_ready      (dut_ready),
    .gen_start      (gen_start),
    .num_qubits     (num_qubits),
    .gate_base      (gate_base),
    .src_is_scratch (src_is_scratch)
  );

  qsim_addr_gen qsim_addr_gen_i (
    .clk                   (clk),
    .reset_n               (reset_n),
    .gen_start             (gen_start),
    .num_qubits            (num_qubits),
    .gate_base             (gate_base),
    .src_is_scratch        (src_is_scratch),
    .result_valid          (result_valid),
    .state_read_address    (state_read_address),
    .gate_read_address     (q_gates_sram_read_address),
    .term_valid            (term_valid),
    .term_first            (term_first),
    .term_last             (term_last),
    .input_write_enable    (q_state_input_sram_write_enable),
    .input_write_address   (q_state_input_sram_write_address),
    .scratch_write_enable  (scratchpad_sram_write_enable),
    .scratch_write_address (scratchpad_sram_write_address),
    .output_write_enable   (q_state_output_sram_write_enable),
    .output_write_address  (q_state_output_sram_write_address),
    .gen_done              (gen_done)
  );

  qsim_cmac qsim_cmac_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .src_is_scratch (src_is_scratch),
    .input_amp      (q_state_input_sram_read_data),
    .scratch_amp    (scratchpad_sram_read_data),
    .coef           (q_gates_sram_read_data),
    .term_valid     (term_valid),
    .term_first     (term_first),
    .term_last      (term_last),
    .result         (result),
    .result_valid   (result_valid)
  );

endmodule
